//--- source/video_pkg.sv
/*
 * video geometry and pixel types for the luma feature path.
 * sized for a 16x8 active area so whole frames simulate quickly.
 * coordinate widths must hold ACTIVE_W-1 and ACTIVE_H-1.
 */
`default_nettype none

package video_pkg;

  // ==================================================
  // active area
  // ==================================================
  localparam int unsigned ACTIVE_W = 16;
  localparam int unsigned ACTIVE_H = 8;
  localparam int unsigned X_W      = 4;
  localparam int unsigned Y_W      = 3;

  // luma weights, they add up to 256
  localparam int unsigned LUMA_R_WT = 77;
  localparam int unsigned LUMA_G_WT = 150;
  localparam int unsigned LUMA_B_WT = 29;

  // red in 23:16, green in 15:8, blue in 7:0
  typedef logic [23:0]    rgb_t;
  typedef logic [7:0]     luma_t;
  typedef logic [X_W-1:0] xcoord_t;
  typedef logic [Y_W-1:0] ycoord_t;

endpackage

`default_nettype wire

//--- source/feature_pkg.sv
/*
 * tile geometry, feature word layout and read port types.
 * feature word is {mean, min, max, edge count}, one byte each.
 * tile ids are row major: tile row * TILES_X + tile column.
 */
`default_nettype none

package feature_pkg;

  // ==================================================
  // tile geometry
  // ==================================================
  localparam int unsigned TILE_SHIFT = 2;
  localparam int unsigned TILES_X    = 4;
  localparam int unsigned TILES_Y    = 2;
  localparam int unsigned TILE_N     = TILES_X * TILES_Y;
  localparam int unsigned TILE_ID_W  = 3;

  // absolute luma step that counts as an edge
  localparam int unsigned EDGE_THR = 16;

  // read port
  localparam int unsigned TAG_W  = 8;
  localparam int unsigned RD_LAT = 2;

  typedef logic [TILE_ID_W-1:0] tile_id_t;
  typedef logic [31:0]          feat_t;
  typedef logic [TAG_W-1:0]     tag_t;
  // sum of 16 pixels of 8 bits
  typedef logic [11:0]          tile_sum_t;
  typedef logic [7:0]           edge_cnt_t;

endpackage

`default_nettype wire

//--- source/luma_stream_if.sv
/*
 * accepted luma pixels with coordinates and frame events.
 * every valid cycle is one pixel, there is no back-pressure.
 * sof, eol and eof mean nothing without valid.
 */
`timescale 1ns/1ps
`default_nettype none

interface luma_stream_if;

  import video_pkg::*;

  logic    valid;
  luma_t   luma;
  xcoord_t x;
  ycoord_t y;
  logic    sof;
  logic    eol;
  logic    eof;

  modport src (
    output valid, luma, x, y, sof, eol, eof
  );

  modport dst (
    input valid, luma, x, y, sof, eol, eof
  );

endinterface

`default_nettype wire

//--- source/video_timing_counter.sv
/*
 * raw video to pixel coordinates and frame events.
 * vsync rising edge arms a frame, de falling edge ends a line.
 * pixels past ACTIVE_W or ACTIVE_H are dropped, hsync is not used.
 */
`timescale 1ns/1ps
`default_nettype none

module video_timing_counter (
  input  logic               clk,
  input  logic               rst_n_i,
  input  logic               en_i,
  input  logic               vsync_i,
  input  logic               de_i,
  input  video_pkg::rgb_t    rgb_i,
  output logic               pix_valid_o,
  output video_pkg::rgb_t    pix_rgb_o,
  output video_pkg::xcoord_t pix_x_o,
  output video_pkg::ycoord_t pix_y_o,
  output logic               sof_o,
  output logic               eol_o,
  output logic               eof_o
);

  import video_pkg::*;

  logic    vsync_q;
  logic    de_q;
  xcoord_t x_q;
  ycoord_t y_q;
  logic    line_full_q;
  logic    frame_done_q;
  logic    vs_rise;
  logic    de_fall;
  logic    sample;
  logic    last_x;
  logic    last_y;

  assign vs_rise = vsync_i && !vsync_q;
  assign de_fall = de_q && !de_i;
  assign sample  = en_i && de_i && !line_full_q && !frame_done_q;
  assign last_x  = (x_q == xcoord_t'(ACTIVE_W - 1));
  assign last_y  = (y_q == ycoord_t'(ACTIVE_H - 1));

  // ==================================================
  // position state
  // ==================================================
  // frame_done starts set, nothing counts before the first vsync
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      vsync_q      <= 1'b0;
      de_q         <= 1'b0;
      x_q          <= '0;
      y_q          <= '0;
      line_full_q  <= 1'b0;
      frame_done_q <= 1'b1;
    end else begin
      vsync_q <= vsync_i;
      de_q    <= de_i;
      if (vs_rise) begin
        x_q          <= '0;
        y_q          <= '0;
        line_full_q  <= 1'b0;
        frame_done_q <= 1'b0;
      end else if (sample) begin
        // x wraps to zero on the last column, line_full blocks the rest
        x_q          <= x_q + 1'b1;
        line_full_q  <= last_x;
        frame_done_q <= last_x && last_y;
      end else if (de_fall && !frame_done_q && (line_full_q || x_q != '0)) begin
        // only lines that carried pixels advance y
        x_q         <= '0;
        line_full_q <= 1'b0;
        if (last_y) begin
          frame_done_q <= 1'b1;
        end else begin
          y_q <= y_q + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pix_valid_o <= 1'b0;
    end else begin
      pix_valid_o <= sample;
    end
  end

  // pixel payload and events
  always_ff @(posedge clk) begin
    if (sample) begin
      pix_rgb_o <= rgb_i;
      pix_x_o   <= x_q;
      pix_y_o   <= y_q;
      sof_o     <= (x_q == '0) && (y_q == '0);
      eol_o     <= last_x;
      eof_o     <= last_x && last_y;
    end
  end

  // no pixel right behind the last column of a line
  assert property (@(posedge clk) disable iff (!rst_n_i)
    (pix_valid_o && eol_o) |=> !pix_valid_o);

endmodule

`default_nettype wire

//--- source/rgb2y_luma.sv
/*
 * two stage rgb to luma, y = (77 r + 150 g + 29 b) >> 8.
 * coordinates and events ride along with each pixel.
 */
`timescale 1ns/1ps
`default_nettype none

module rgb2y_luma (
  input  logic               clk,
  input  logic               rst_n_i,
  input  logic               pix_valid_i,
  input  video_pkg::rgb_t    pix_rgb_i,
  input  video_pkg::xcoord_t pix_x_i,
  input  video_pkg::ycoord_t pix_y_i,
  input  logic               sof_i,
  input  logic               eol_i,
  input  logic               eof_i,
  luma_stream_if.src         stream_o
);

  import video_pkg::*;

  // stage one, weighted products
  logic        s1_valid_q;
  logic [14:0] r_prod_q;
  logic [15:0] g_prod_q;
  logic [12:0] b_prod_q;
  xcoord_t     s1_x_q;
  ycoord_t     s1_y_q;
  logic        s1_sof_q;
  logic        s1_eol_q;
  logic        s1_eof_q;

  // stage two, luma
  logic        s2_valid_q;
  luma_t       s2_luma_q;
  xcoord_t     s2_x_q;
  ycoord_t     s2_y_q;
  logic        s2_sof_q;
  logic        s2_eol_q;
  logic        s2_eof_q;
  logic [15:0] wsum;

  // peaks at 255 * 256, no carry out of 16 bits
  assign wsum = 16'(r_prod_q) + g_prod_q + 16'(b_prod_q);

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else begin
      s1_valid_q <= pix_valid_i;
      s2_valid_q <= s1_valid_q;
    end
  end

  always_ff @(posedge clk) begin
    r_prod_q  <= 15'(pix_rgb_i[23:16] * LUMA_R_WT);
    g_prod_q  <= 16'(pix_rgb_i[15:8] * LUMA_G_WT);
    b_prod_q  <= 13'(pix_rgb_i[7:0] * LUMA_B_WT);
    s1_x_q    <= pix_x_i;
    s1_y_q    <= pix_y_i;
    s1_sof_q  <= sof_i;
    s1_eol_q  <= eol_i;
    s1_eof_q  <= eof_i;

    s2_luma_q <= wsum[15:8];
    s2_x_q    <= s1_x_q;
    s2_y_q    <= s1_y_q;
    s2_sof_q  <= s1_sof_q;
    s2_eol_q  <= s1_eol_q;
    s2_eof_q  <= s1_eof_q;
  end

  assign stream_o.valid = s2_valid_q;
  assign stream_o.luma  = s2_luma_q;
  assign stream_o.x     = s2_x_q;
  assign stream_o.y     = s2_y_q;
  assign stream_o.sof   = s2_sof_q;
  assign stream_o.eol   = s2_eol_q;
  assign stream_o.eof   = s2_eof_q;

endmodule

`default_nettype wire

//--- source/tile_stats_accum.sv
/*
 * per tile sum, min, max and edge count over 4x4 tiles.
 * one accumulator set per tile column, reused for each tile row.
 * expects raster order, a finished tile is written one cycle later.
 */
`timescale 1ns/1ps
`default_nettype none

module tile_stats_accum (
  input  logic                  clk,
  input  logic                  rst_n_i,
  luma_stream_if.dst            stream_i,
  output logic                  wr_valid_o,
  output feature_pkg::tile_id_t wr_tile_o,
  output feature_pkg::feat_t    wr_feat_o
);

  import video_pkg::*;
  import feature_pkg::*;

  tile_sum_t sum_q  [TILES_X];
  luma_t     min_q  [TILES_X];
  luma_t     max_q  [TILES_X];
  edge_cnt_t edge_q [TILES_X];
  luma_t     prev_q;

  logic [X_W-TILE_SHIFT-1:0] col;
  logic [Y_W-TILE_SHIFT-1:0] row;
  logic                      complete;
  tile_sum_t                 sum_nx;
  luma_t                     min_nx;
  luma_t                     max_nx;
  edge_cnt_t                 edge_nx;
  tile_sum_t                 sum_base;
  luma_t                     min_base;
  luma_t                     max_base;
  edge_cnt_t                 edge_base;
  luma_t                     diff;
  logic                      is_edge;

  assign col = stream_i.x[X_W-1:TILE_SHIFT];
  assign row = stream_i.y[Y_W-1:TILE_SHIFT];
  // bottom right pixel of a tile
  assign complete = stream_i.valid && (&stream_i.x[TILE_SHIFT-1:0])
                    && (&stream_i.y[TILE_SHIFT-1:0]);

  // ==================================================
  // next values for the current column
  // ==================================================
  always_comb begin
    // sof starts from empty, the stored column may hold an older frame
    sum_base  = stream_i.sof ? '0 : sum_q[col];
    min_base  = stream_i.sof ? '1 : min_q[col];
    max_base  = stream_i.sof ? '0 : max_q[col];
    edge_base = stream_i.sof ? '0 : edge_q[col];

    sum_nx = sum_base + tile_sum_t'(stream_i.luma);
    min_nx = (stream_i.luma < min_base) ? stream_i.luma : min_base;
    max_nx = (stream_i.luma > max_base) ? stream_i.luma : max_base;

    diff = (stream_i.luma > prev_q) ? stream_i.luma - prev_q : prev_q - stream_i.luma;
    // no pair across a tile column boundary
    is_edge = (stream_i.x[TILE_SHIFT-1:0] != '0) && (int'(diff) > EDGE_THR);
    edge_nx = edge_base + edge_cnt_t'(is_edge && (edge_base != '1));
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < TILES_X; i++) begin
        sum_q[i]  <= '0;
        min_q[i]  <= '1;
        max_q[i]  <= '0;
        edge_q[i] <= '0;
      end
    end else if (stream_i.valid) begin
      for (int i = 0; i < TILES_X; i++) begin
        if ((int'(col) == i) && !complete) begin
          sum_q[i]  <= sum_nx;
          min_q[i]  <= min_nx;
          max_q[i]  <= max_nx;
          edge_q[i] <= edge_nx;
        end else if (stream_i.sof || (int'(col) == i)) begin
          // new frame, or this column's tile was just written
          sum_q[i]  <= '0;
          min_q[i]  <= '1;
          max_q[i]  <= '0;
          edge_q[i] <= '0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (stream_i.valid) begin
      prev_q <= stream_i.luma;
    end
  end

  // ==================================================
  // feature write
  // ==================================================
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_valid_o <= 1'b0;
    end else begin
      wr_valid_o <= complete;
    end
  end

  always_ff @(posedge clk) begin
    if (complete) begin
      wr_tile_o <= tile_id_t'(row) * tile_id_t'(TILES_X) + tile_id_t'(col);
      wr_feat_o <= {luma_t'(sum_nx >> (2 * TILE_SHIFT)), min_nx, max_nx, edge_nx};
    end
  end

  // tiles of one row finish 4 pixels apart
  assert property (@(posedge clk) disable iff (!rst_n_i)
    wr_valid_o |=> !(wr_valid_o && (wr_tile_o == $past(wr_tile_o))));

  // line end sits in the last tile column
  assert property (@(posedge clk) disable iff (!rst_n_i)
    (stream_i.valid && stream_i.eol) |-> (int'(col) == TILES_X - 1));

  // frame end closes the last tile row
  assert property (@(posedge clk) disable iff (!rst_n_i)
    (stream_i.valid && stream_i.eof) |-> (complete && (int'(row) == TILES_Y - 1)));

endmodule

`default_nettype wire

//--- source/feature_sram.sv
/*
 * tile feature memory with a tagged valid/ready read port.
 * read latency is RD_LAT cycles into an empty output buffer.
 * a write in the same cycle as the read is returned.
 */
`timescale 1ns/1ps
`default_nettype none

module feature_sram (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic                  wr_valid_i,
  input  feature_pkg::tile_id_t wr_tile_i,
  input  feature_pkg::feat_t    wr_feat_i,
  input  logic                  rd_valid_i,
  input  feature_pkg::tile_id_t rd_tile_i,
  input  feature_pkg::tag_t     rd_tag_i,
  input  logic                  feat_ready_i,
  output logic                  rd_ready_o,
  output logic                  feat_valid_o,
  output feature_pkg::tag_t     feat_tag_o,
  output feature_pkg::feat_t    feat_data_o
);

  import feature_pkg::*;

  feat_t    mem_q [TILE_N];

  // request stage
  logic     req_valid_q;
  tile_id_t req_tile_q;
  tag_t     req_tag_q;

  // two entry response buffer
  feat_t    buf_data_q [RD_LAT];
  tag_t     buf_tag_q  [RD_LAT];
  logic     wr_ptr_q;
  logic     rd_ptr_q;
  logic [1:0] cnt_q;

  logic     rd_ready_q;
  logic     rd_fire;
  logic     pop;
  feat_t    rd_data;
  logic [2:0] occ_nx;

  assign rd_fire      = rd_valid_i && rd_ready_q;
  assign pop          = feat_valid_o && feat_ready_i;
  assign rd_ready_o   = rd_ready_q;
  assign feat_valid_o = (cnt_q != '0);
  assign feat_data_o  = buf_data_q[rd_ptr_q];
  assign feat_tag_o   = buf_tag_q[rd_ptr_q];

  // write first for the tile in the request stage
  assign rd_data = (wr_valid_i && (wr_tile_i == req_tile_q)) ? wr_feat_i
                                                             : mem_q[req_tile_q];

  // requests in flight plus held responses after this edge
  assign occ_nx = 3'(cnt_q) + 3'(req_valid_q) + 3'(rd_fire) - 3'(pop);

  // ==================================================
  // control and memory
  // ==================================================
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < TILE_N; i++) begin
        mem_q[i] <= '0;
      end
      req_valid_q <= 1'b0;
      wr_ptr_q    <= 1'b0;
      rd_ptr_q    <= 1'b0;
      cnt_q       <= '0;
      rd_ready_q  <= 1'b0;
    end else begin
      if (wr_valid_i) begin
        mem_q[wr_tile_i] <= wr_feat_i;
      end
      req_valid_q <= rd_fire;
      // a new request must always find a buffer slot
      rd_ready_q  <= (int'(occ_nx) < RD_LAT);
      if (req_valid_q) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      cnt_q <= cnt_q + 2'(req_valid_q) - 2'(pop);
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire) begin
      req_tile_q <= rd_tile_i;
      req_tag_q  <= rd_tag_i;
    end
    if (req_valid_q) begin
      buf_data_q[wr_ptr_q] <= rd_data;
      buf_tag_q[wr_ptr_q]  <= req_tag_q;
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n_i)
    (feat_valid_o && !feat_ready_i) |=>
      (feat_valid_o && $stable(feat_data_o) && $stable(feat_tag_o)));

endmodule

`default_nettype wire

//--- source/luma_feature_top.sv
/*
 * luma front end and tile feature back end under one top.
 * hsync_i is only part of the video port, lines end on de.
 */
`timescale 1ns/1ps
`default_nettype none

module luma_feature_top (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic                  en_i,
  input  logic                  vsync_i,
  input  logic                  hsync_i,
  input  logic                  de_i,
  input  video_pkg::rgb_t       rgb_i,
  input  logic                  rd_valid_i,
  input  feature_pkg::tile_id_t rd_tile_i,
  input  feature_pkg::tag_t     rd_tag_i,
  input  logic                  feat_ready_i,
  output logic                  rd_ready_o,
  output logic                  feat_valid_o,
  output feature_pkg::tag_t     feat_tag_o,
  output feature_pkg::feat_t    feat_data_o,
  output logic                  wr_valid_o,
  output feature_pkg::tile_id_t wr_tile_o
);

  import video_pkg::*;
  import feature_pkg::*;

  logic    pix_valid;
  rgb_t    pix_rgb;
  xcoord_t pix_x;
  ycoord_t pix_y;
  logic    pix_sof;
  logic    pix_eol;
  logic    pix_eof;
  feat_t   wr_feat;

  // ==================================================
  // front end
  // ==================================================
  video_timing_counter video_timing_counter_i (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .en_i        (en_i),
    .vsync_i     (vsync_i),
    .de_i        (de_i),
    .rgb_i       (rgb_i),
    .pix_valid_o (pix_valid),
    .pix_rgb_o   (pix_rgb),
    .pix_x_o     (pix_x),
    .pix_y_o     (pix_y),
    .sof_o       (pix_sof),
    .eol_o       (pix_eol),
    .eof_o       (pix_eof)
  );

  luma_stream_if luma_stream_i ();

  rgb2y_luma rgb2y_luma_i (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .pix_valid_i (pix_valid),
    .pix_rgb_i   (pix_rgb),
    .pix_x_i     (pix_x),
    .pix_y_i     (pix_y),
    .sof_i       (pix_sof),
    .eol_i       (pix_eol),
    .eof_i       (pix_eof),
    .stream_o    (luma_stream_i)
  );

  // ==================================================
  // back end
  // ==================================================
  tile_stats_accum tile_stats_accum_i (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .stream_i   (luma_stream_i),
    .wr_valid_o (wr_valid_o),
    .wr_tile_o  (wr_tile_o),
    .wr_feat_o  (wr_feat)
  );

  feature_sram feature_sram_i (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .wr_valid_i   (wr_valid_o),
    .wr_tile_i    (wr_tile_o),
    .wr_feat_i    (wr_feat),
    .rd_valid_i   (rd_valid_i),
    .rd_tile_i    (rd_tile_i),
    .rd_tag_i     (rd_tag_i),
    .feat_ready_i (feat_ready_i),
    .rd_ready_o   (rd_ready_o),
    .feat_valid_o (feat_valid_o),
    .feat_tag_o   (feat_tag_o),
    .feat_data_o  (feat_data_o)
  );

endmodule

`default_nettype wire

//--- tb/tb_feature_model.svh
/*
 * reference model for the luma feature testbench, included in the tb module.
 * holds the LFSR, the active frame in luma and the expected feature words.
 * tiles are 4x4 over a 16x8 frame, ids run row major.
 */
`ifndef TB_FEATURE_MODEL_SVH
`define TB_FEATURE_MODEL_SVH

localparam int IMG_W        = 16;
localparam int IMG_H        = 8;
localparam int TILE_DIM     = 4;
localparam int TILES_ACROSS = 4;
localparam int TILE_COUNT   = 8;
localparam int EDGE_LIMIT   = 16;

// fibonacci lfsr, taps 32 22 2 1
logic [31:0] lfsr_state = 32'hb064_2b95;

// luma of the active frame, [y][x]
logic [7:0]  frame_luma [IMG_H][IMG_W];
logic [31:0] exp_feat   [TILE_COUNT];

// one lfsr step per bit taken
function automatic logic [31:0] rand_bits(input int n);
  logic        fb;
  logic [31:0] r;
  r = '0;
  for (int i = 0; i < n; i++) begin
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    r = {r[30:0], fb};
  end
  return r;
endfunction

// y = (77 r + 150 g + 29 b) >> 8
function automatic logic [7:0] luma_of(input logic [23:0] rgb);
  int acc;
  acc = 77 * int'(rgb[23:16]) + 150 * int'(rgb[15:8]) + 29 * int'(rgb[7:0]);
  return 8'(acc >> 8);
endfunction

// {mean, min, max, edge count} of one tile
function automatic logic [31:0] tile_feature(input int tile);
  int x0;
  int y0;
  int sum;
  int lo;
  int hi;
  int edges;
  int d;
  x0 = (tile % TILES_ACROSS) * TILE_DIM;
  y0 = (tile / TILES_ACROSS) * TILE_DIM;
  sum = 0;
  lo = 255;
  hi = 0;
  edges = 0;
  for (int y = y0; y < y0 + TILE_DIM; y++) begin
    for (int x = x0; x < x0 + TILE_DIM; x++) begin
      sum += int'(frame_luma[y][x]);
      if (int'(frame_luma[y][x]) < lo) begin
        lo = int'(frame_luma[y][x]);
      end
      if (int'(frame_luma[y][x]) > hi) begin
        hi = int'(frame_luma[y][x]);
      end
      // pairs stay inside the tile's row segment
      if (x > x0) begin
        d = int'(frame_luma[y][x]) - int'(frame_luma[y][x-1]);
        if (d < 0) begin
          d = -d;
        end
        if (d > EDGE_LIMIT && edges < 255) begin
          edges++;
        end
      end
    end
  end
  return {8'(sum >> 4), 8'(lo), 8'(hi), 8'(edges)};
endfunction

`endif

//--- tb/tb_luma_feature_top.sv
/*
 * testbench for luma_feature_top: random frames, tile reads and checks.
 * inputs change on the falling clock edge, outputs are sampled there too.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_luma_feature_top;

  // longest frame: 10 lines of 20 pixels, idle cycles included
  localparam int FRAME_CYC    = 2 + 10 * (2 * 20 + 5) + 10;
  localparam int NUM_FRAMES   = 5;
  localparam int WATCHDOG_CYC = NUM_FRAMES * FRAME_CYC * 4;

  logic        clk = 1'b0;
  logic        rst_n_i;
  logic        en_i;
  logic        vsync_i;
  logic        hsync_i;
  logic        de_i;
  logic [23:0] rgb_i;
  logic        rd_valid_i;
  logic [2:0]  rd_tile_i;
  logic [7:0]  rd_tag_i;
  logic        feat_ready_i;
  logic        rd_ready_o;
  logic        feat_valid_o;
  logic [7:0]  feat_tag_o;
  logic [31:0] feat_data_o;
  logic        wr_valid_o;
  logic [2:0]  wr_tile_o;

  logic [2:0]  wr_seen [$];
  int          writes_before_last_row;
  string       cur_test;
  int          test_err_base;
  int          err_cnt;
  int          chk_cnt;
  int          test_cnt;
  int          test_fail;

  luma_feature_top luma_feature_top_i (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .en_i         (en_i),
    .vsync_i      (vsync_i),
    .hsync_i      (hsync_i),
    .de_i         (de_i),
    .rgb_i        (rgb_i),
    .rd_valid_i   (rd_valid_i),
    .rd_tile_i    (rd_tile_i),
    .rd_tag_i     (rd_tag_i),
    .feat_ready_i (feat_ready_i),
    .rd_ready_o   (rd_ready_o),
    .feat_valid_o (feat_valid_o),
    .feat_tag_o   (feat_tag_o),
    .feat_data_o  (feat_data_o),
    .wr_valid_o   (wr_valid_o),
    .wr_tile_o    (wr_tile_o)
  );

  `include "tb_feature_model.svh"

  // ==================================================
  // bookkeeping
  // ==================================================
  task automatic expect_equal(input string what, input logic [31:0] exp,
                              input logic [31:0] act);
    chk_cnt++;
    assert (exp == act) else begin
      $display("[ERROR] %s: %s expected 0x%08h actual 0x%08h", cur_test, what, exp, act);
      err_cnt++;
    end
  endtask

  task automatic expect_true(input logic cond, input string msg);
    chk_cnt++;
    assert (cond) else begin
      $display("[ERROR] %s: %s", cur_test, msg);
      err_cnt++;
    end
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    test_err_base = err_cnt;
  endtask

  task automatic finish_test();
    test_cnt++;
    if (err_cnt == test_err_base) begin
      $display("[TEST] %s ok", cur_test);
    end else begin
      test_fail++;
      $display("[TEST] %s had %0d errors", cur_test, err_cnt - test_err_base);
    end
  endtask

  // falling edge, also logs tile writes
  task automatic next_cycle();
    @(negedge clk);
    if (wr_valid_o) begin
      wr_seen.push_back(wr_tile_o);
    end
  endtask

  // ==================================================
  // video side
  // ==================================================
  task automatic drive_frame(input int w, input int h, input logic gated);
    logic [23:0] rgb;
    wr_seen.delete();
    writes_before_last_row = 0;
    en_i = !gated;
    vsync_i = 1'b1;
    repeat (2) next_cycle();
    vsync_i = 1'b0;
    for (int y = 0; y < h; y++) begin
      if (y == IMG_H - 1) begin
        writes_before_last_row = wr_seen.size();
      end
      // de low between lines ends the previous one
      de_i = 1'b0;
      hsync_i = 1'b1;
      next_cycle();
      hsync_i = 1'b0;
      repeat (int'(rand_bits(2))) next_cycle();
      for (int x = 0; x < w; x++) begin
        de_i = 1'b1;
        if (!gated && rand_bits(2) == 0) begin
          en_i = 1'b0;
          next_cycle();
          en_i = 1'b1;
        end
        rgb = 24'(rand_bits(24));
        rgb_i = rgb;
        if (!gated && x < IMG_W && y < IMG_H) begin
          frame_luma[y][x] = luma_of(rgb);
        end
        next_cycle();
      end
    end
    de_i = 1'b0;
    // pipeline drain, last tile lands 4 cycles after its pixel
    repeat (10) next_cycle();
    en_i = 1'b1;
    if (!gated) begin
      foreach (exp_feat[t]) begin
        exp_feat[t] = tile_feature(t);
      end
    end
  endtask

  task automatic check_write_order(input logic writes_expected);
    if (!writes_expected) begin
      expect_equal("feature writes", 0, 32'(wr_seen.size()));
    end else begin
      expect_equal("feature writes", 32'(TILE_COUNT), 32'(wr_seen.size()));
      expect_equal("writes before last row", 32'(TILES_ACROSS), 32'(writes_before_last_row));
      foreach (wr_seen[i]) begin
        expect_equal("written tile id", 32'(i % TILE_COUNT), 32'(wr_seen[i]));
      end
    end
  endtask

  // ==================================================
  // read side
  // ==================================================
  task automatic measure_read_latency(input logic [2:0] tile, input logic [7:0] tag);
    int n;
    n = 0;
    feat_ready_i = 1'b1;
    next_cycle();
    while (!(rd_ready_o && !feat_valid_o) && n < 16) begin
      next_cycle();
      n++;
    end
    expect_true(rd_ready_o && !feat_valid_o, "read port never became idle");
    rd_valid_i = 1'b1;
    rd_tile_i = tile;
    rd_tag_i = tag;
    next_cycle();
    rd_valid_i = 1'b0;
    n = 1;
    while (!feat_valid_o && n < 8) begin
      next_cycle();
      n++;
    end
    expect_equal("cycles to feat_valid_o", 32'd2, 32'(n));
    expect_equal("response tag", 32'(tag), 32'(feat_tag_o));
    expect_equal("response data", exp_feat[tile], feat_data_o);
    next_cycle();
    expect_true(!feat_valid_o, "second response after a single read");
  endtask

  // back to back requests, ready low about one cycle in 2**stall_bits
  task automatic read_burst(input int n, input logic any_tile, input int stall_bits);
    logic [10:0] req_q [$];
    logic [10:0] ent;
    logic [2:0]  tile;
    logic [7:0]  tag;
    logic        ready;
    logic        held;
    logic [31:0] held_data;
    logic [7:0]  held_tag;
    int          issued;
    int          got;
    int          guard;
    issued = 0;
    got = 0;
    guard = 0;
    held = 1'b0;
    held_data = '0;
    held_tag = '0;
    tile = any_tile ? 3'(rand_bits(3)) : 3'd0;
    tag = 8'(rand_bits(8));
    while (got < n && guard < n * 20) begin
      next_cycle();
      guard++;
      if (held) begin
        expect_true(feat_valid_o, "response withdrawn while stalled");
        expect_equal("stalled data", held_data, feat_data_o);
        expect_equal("stalled tag", 32'(held_tag), 32'(feat_tag_o));
      end
      held = 1'b0;
      ready = (stall_bits == 0) || (rand_bits(stall_bits) != 0);
      feat_ready_i = ready;
      if (feat_valid_o && ready) begin
        got++;
        if (req_q.size() == 0) begin
          expect_true(1'b0, "response without a request");
        end else begin
          ent = req_q.pop_front();
          expect_equal("response tag", 32'(ent[7:0]), 32'(feat_tag_o));
          expect_equal("response data", exp_feat[ent[10:8]], feat_data_o);
        end
      end else if (feat_valid_o) begin
        held = 1'b1;
        held_data = feat_data_o;
        held_tag = feat_tag_o;
      end
      if (issued < n) begin
        rd_valid_i = 1'b1;
        rd_tile_i = tile;
        rd_tag_i = tag;
        // transfers on the coming rising edge
        if (rd_ready_o) begin
          req_q.push_back({tile, tag});
          issued++;
          tile = any_tile ? 3'(rand_bits(3)) : 3'(issued % TILE_COUNT);
          tag = 8'(rand_bits(8));
        end
      end else begin
        rd_valid_i = 1'b0;
      end
    end
    rd_valid_i = 1'b0;
    feat_ready_i = 1'b1;
    expect_equal("responses", 32'(n), 32'(got));
    expect_equal("requests left", 0, 32'(req_q.size()));
    repeat (3) begin
      next_cycle();
      expect_true(!feat_valid_o, "response after the burst ended");
    end
  endtask

  // ==================================================
  // clock, watchdog, sequence
  // ==================================================
  initial begin
    forever #50 clk = ~clk;
  end

  initial begin
    repeat (WATCHDOG_CYC) @(posedge clk);
    $display("[ERROR] watchdog expired after %0d cycles, run stopped", WATCHDOG_CYC);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    rst_n_i = 1'b0;
    en_i = 1'b0;
    vsync_i = 1'b0;
    hsync_i = 1'b0;
    de_i = 1'b0;
    rgb_i = '0;
    rd_valid_i = 1'b0;
    rd_tile_i = '0;
    rd_tag_i = '0;
    feat_ready_i = 1'b1;
    err_cnt = 0;
    chk_cnt = 0;
    test_cnt = 0;
    test_fail = 0;
    cur_test = "reset";
    // memory is zero after reset
    foreach (exp_feat[t]) begin
      exp_feat[t] = '0;
    end
    repeat (4) next_cycle();
    rst_n_i = 1'b1;
    en_i = 1'b1;

    start_test("read_latency");
    for (int t = 0; t < TILE_COUNT; t++) begin
      measure_read_latency(3'(t), 8'(rand_bits(8)));
    end
    finish_test();

    for (int f = 0; f < 3; f++) begin
      drive_frame(IMG_W, IMG_H, 1'b0);
      start_test($sformatf("frame%0d_writes", f));
      check_write_order(1'b1);
      finish_test();
      start_test($sformatf("frame%0d_features", f));
      read_burst(TILE_COUNT, 1'b0, 2);
      finish_test();
    end

    start_test("tag_order");
    read_burst(24, 1'b1, 1);
    finish_test();

    // en_i low for a whole frame, memory must keep the last frame
    drive_frame(IMG_W, IMG_H, 1'b1);
    start_test("enable_gating");
    check_write_order(1'b0);
    read_burst(TILE_COUNT, 1'b0, 2);
    finish_test();

    drive_frame(IMG_W + 4, IMG_H + 2, 1'b0);
    start_test("bounds");
    check_write_order(1'b1);
    read_burst(TILE_COUNT, 1'b0, 2);
    finish_test();

    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             test_cnt, test_fail, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
+incdir+tb
source/video_pkg.sv
source/feature_pkg.sv
source/luma_stream_if.sv
source/video_timing_counter.sv
source/rgb2y_luma.sv
source/tile_stats_accum.sv
source/feature_sram.sv
source/luma_feature_top.sv
tb/tb_luma_feature_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the luma feature testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f sim.f \
  --top-module tb_luma_feature_top -o sim_tb

# the log decides the result, not the exit status of the run
./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
  echo "simulation ok, log in sim.log"
  exit 0
fi

echo "simulation not ok, see sim.log"
exit 1
